//--- Makefile
VERILATOR ?= verilator
TOP       ?= cpu_tb
FILELIST  ?= cpu_top.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Test completed successfully

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- cpu_top.f
src/cpu_pkg.sv
src/inst_queue.sv
src/decoder.sv
src/reg_file.sv
src/hazard_unit.sv
src/alu.sv
src/data_mem.sv
src/cpu_top.sv
dv/cpu_tb.sv

//--- dv/cpu_tb.sv
`timescale 1ns/10ps

module cpu_tb;

  localparam int N_IMM          = 40;
  localparam int N_RR           = 80;
  localparam int N_FWD          = 60;
  localparam int N_MEM          = 20;
  localparam int N_ZERO         = 30;
  localparam int TOTAL_INSTS    = N_IMM + N_RR + N_FWD + 3 * N_MEM + N_ZERO;
  localparam int TIMEOUT_CYCLES = 20 * TOTAL_INSTS + 400;

  logic           clk;
  logic           rst;
  logic           inst_valid;
  cpu_pkg::inst_u inst;
  logic           credit_return;
  cpu_pkg::wb_t   wb;

  logic [31:0]  rng_state = 32'h3f5f;
  logic [31:0]  model_regs [32];
  logic [31:0]  model_mem [64];
  cpu_pkg::wb_t expected [$];
  int credits;
  int sent;
  int credit_pulses;
  int checks;
  int errors;
  int tests;

  cpu_top i_cpu_top (
    .clk           (clk),
    .rst           (rst),
    .inst_valid    (inst_valid),
    .inst          (inst),
    .credit_return (credit_return),
    .wb            (wb)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // random helpers and instruction builders
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] xorshift();
    rng_state ^= rng_state << 13;
    rng_state ^= rng_state >> 17;
    rng_state ^= rng_state << 5;
    return rng_state;
  endfunction

  function automatic logic [4:0] any_reg();
    logic [31:0] r;
    r = xorshift();
    return r[4:0];
  endfunction

  function automatic logic [4:0] nonzero_reg();
    logic [31:0] r;
    r = xorshift();
    return 5'(r % 31 + 1);
  endfunction

  function automatic cpu_pkg::opcode_e rr_op();
    logic [31:0] r;
    r = xorshift();
    case (r % 5)
      0:       return cpu_pkg::ADD;
      1:       return cpu_pkg::SUB;
      2:       return cpu_pkg::AND;
      3:       return cpu_pkg::OR;
      default: return cpu_pkg::SLT;
    endcase
  endfunction

  function automatic cpu_pkg::inst_u r_type(input cpu_pkg::opcode_e op,
                                            input logic [4:0] rs, rt, rd);
    cpu_pkg::inst_u w;
    w          = '0;
    w.r.opcode = op;
    w.r.rs     = rs;
    w.r.rt     = rt;
    w.r.rd     = rd;
    return w;
  endfunction

  function automatic cpu_pkg::inst_u i_type(input cpu_pkg::opcode_e op,
                                            input logic [4:0] rs, rt,
                                            input logic [15:0] imm);
    cpu_pkg::inst_u w;
    w          = '0;
    w.i.opcode = op;
    w.i.rs     = rs;
    w.i.rt     = rt;
    w.i.imm    = imm;
    return w;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // reference model
  ////////////////////////////////////////////////////////////////////////////

  // in-order execution, one expected write per register result
  task automatic model_exec(input cpu_pkg::inst_u w);
    logic [31:0]  a;
    logic [31:0]  b;
    logic [31:0]  imm;
    logic [31:0]  res;
    logic [4:0]   dst;
    logic [5:0]   addr;
    logic         writes;
    cpu_pkg::wb_t item;
    a      = model_regs[w.r.rs];
    b      = model_regs[w.r.rt];
    imm    = {16'h0, w.i.imm};
    addr   = 6'(a + imm);
    dst    = w.r.rd;
    res    = '0;
    writes = 1'b1;
    case (w.r.opcode)
      cpu_pkg::ADD:  res = a + b;
      cpu_pkg::SUB:  res = a - b;
      cpu_pkg::AND:  res = a & b;
      cpu_pkg::OR:   res = a | b;
      cpu_pkg::SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      cpu_pkg::ADDI: begin
        res = a + imm;
        dst = w.i.rt;
      end
      cpu_pkg::ORI: begin
        res = a | imm;
        dst = w.i.rt;
      end
      cpu_pkg::LW: begin
        res = model_mem[addr];
        dst = w.i.rt;
      end
      cpu_pkg::SW: begin
        model_mem[addr] = b;
        writes          = 1'b0;
      end
      default: writes = 1'b0;
    endcase
    if (writes && dst != 5'd0) begin
      model_regs[dst] = res;
      item.valid      = 1'b1;
      item.dest       = dst;
      item.data       = res;
      expected.push_back(item);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // sender, monitor and checks
  ////////////////////////////////////////////////////////////////////////////

  // waits for a credit and a random go, so the queue fills now and then
  task automatic send(input cpu_pkg::inst_u w);
    logic [31:0] r;
    @(posedge clk);
    r = xorshift();
    while (credits == 0 || r[1:0] == 2'b00) begin
      inst_valid <= 1'b0;
      @(posedge clk);
      r = xorshift();
    end
    inst_valid <= 1'b1;
    inst       <= w;
    credits--;
    sent++;
    model_exec(w);
  endtask

  task automatic report_mismatch(input string sig, input logic [31:0] exp, act);
    $display("** Error at %0t: %s expected %h, got %h", $time, sig, exp, act);
    errors++;
  endtask

  task automatic check_write();
    cpu_pkg::wb_t exp;
    checks++;
    assert (wb.dest != 5'd0) else begin
      $display("write-back to register zero seen at %0t", $time);
      errors++;
    end
    assert (expected.size() != 0) else begin
      $display("write-back to r%0d at %0t with no write expected", wb.dest, $time);
      errors++;
    end
    if (expected.size() != 0) begin
      exp = expected.pop_front();
      assert (wb.dest == exp.dest) else report_mismatch("wb.dest", 32'(exp.dest), 32'(wb.dest));
      assert (wb.data == exp.data) else report_mismatch("wb.data", exp.data, wb.data);
    end
  endtask

  always @(negedge clk) begin
    if (!rst) begin
      if (credit_return) begin
        assert (credits < cpu_pkg::QUEUE_DEPTH) else begin
          $display("credit returned at %0t with no instruction outstanding", $time);
          errors++;
        end
        credits++;
        credit_pulses++;
      end
      if (wb.valid) begin
        check_write();
      end
    end
  end

  // all credits back and every write seen
  task automatic finish_test(input string name, input int start_errors);
    @(posedge clk);
    inst_valid <= 1'b0;
    while (expected.size() != 0 || credits != cpu_pkg::QUEUE_DEPTH) begin
      @(negedge clk);
    end
    repeat (6) @(negedge clk);
    tests++;
    $display("test %s: %0d errors", name, errors - start_errors);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic run_imm_ops();
    logic [31:0] r;
    int start;
    start = errors;
    for (int k = 0; k < N_IMM; k++) begin
      r = xorshift();
      send(i_type(r[0] ? cpu_pkg::ADDI : cpu_pkg::ORI, any_reg(), nonzero_reg(), r[31:16]));
    end
    finish_test("imm_ops", start);
  endtask

  task automatic run_rr_ops();
    int start;
    start = errors;
    for (int k = 0; k < N_RR; k++) begin
      send(r_type(rr_op(), any_reg(), any_reg(), nonzero_reg()));
    end
    finish_test("rr_ops", start);
  endtask

  // sources taken from the last two destinations
  task automatic run_forwarding();
    logic [31:0] r;
    logic [4:0]  d1;
    logic [4:0]  d2;
    logic [4:0]  near;
    logic [4:0]  other;
    logic [4:0]  dst;
    int start;
    start = errors;
    d1    = 5'd1;
    d2    = 5'd2;
    for (int k = 0; k < N_FWD; k++) begin
      r     = xorshift();
      near  = r[0] ? d1 : d2;
      other = r[1] ? d2 : any_reg();
      dst   = nonzero_reg();
      if (r[2]) begin
        send(i_type(cpu_pkg::ADDI, near, dst, r[31:16]));
      end else if (r[3]) begin
        send(r_type(rr_op(), near, other, dst));
      end else begin
        send(r_type(rr_op(), other, near, dst));
      end
      d2 = d1;
      d1 = dst;
    end
    finish_test("forwarding", start);
  endtask

  // store, load back, then use at once
  task automatic run_memory();
    logic [31:0] r;
    logic [4:0]  base;
    logic [4:0]  src;
    logic [4:0]  ld;
    int start;
    start = errors;
    for (int k = 0; k < N_MEM; k++) begin
      r    = xorshift();
      base = any_reg();
      src  = any_reg();
      ld   = nonzero_reg();
      send(i_type(cpu_pkg::SW, base, src, r[15:0]));
      send(i_type(cpu_pkg::LW, base, ld, r[15:0]));
      send(r_type(cpu_pkg::ADD, ld, src, nonzero_reg()));
    end
    finish_test("memory", start);
  endtask

  task automatic run_zero_reg();
    logic [31:0] r;
    int start;
    start = errors;
    for (int k = 0; k < N_ZERO; k++) begin
      r = xorshift();
      case (r % 4)
        0:       send(r_type(rr_op(), any_reg(), any_reg(), 5'd0));
        1:       send(i_type(r[4] ? cpu_pkg::ADDI : cpu_pkg::ORI, any_reg(), 5'd0, r[31:16]));
        2:       send(i_type(cpu_pkg::SW, any_reg(), any_reg(), r[31:16]));
        default: send(r_type(cpu_pkg::OR, 5'd0, r[4] ? 5'd0 : any_reg(), nonzero_reg()));
      endcase
    end
    finish_test("zero_reg", start);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // main sequence and watchdog
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    rst        = 1'b1;
    inst_valid = 1'b0;
    inst       = '0;
    credits    = cpu_pkg::QUEUE_DEPTH;
    for (int i = 0; i < 32; i++) begin
      model_regs[i] = '0;
    end
    for (int i = 0; i < 64; i++) begin
      model_mem[i] = '0;
    end
    repeat (16) @(posedge clk);
    rst <= 1'b0;

    run_imm_ops();
    run_rr_ops();
    run_forwarding();
    run_memory();
    run_zero_reg();

    assert (credit_pulses == sent) else begin
      $display("%0d credits returned for %0d instructions sent", credit_pulses, sent);
      errors++;
    end
    $display("tests %0d, instructions %0d, checks %0d, errors %0d", tests, sent, checks, errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  initial begin
    repeat (TIMEOUT_CYCLES + 16) @(posedge clk);
    $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("Test failed");
    $finish;
  end

endmodule

//--- src/alu.sv
`timescale 1ns/10ps

module alu (
  input  logic [cpu_pkg::DATA_WIDTH-1:0] op_a,
  input  logic [cpu_pkg::DATA_WIDTH-1:0] op_b_reg,
  input  logic [cpu_pkg::IMM_WIDTH-1:0]  imm,
  input  cpu_pkg::ctrl_t                 ctrl,
  output logic [cpu_pkg::DATA_WIDTH-1:0] result,
  output logic [cpu_pkg::DATA_WIDTH-1:0] store_data
);

  logic [cpu_pkg::DATA_WIDTH-1:0] op_b;

  // immediate is zero-extended
  assign op_b = ctrl.alu_src_imm ?
                {{(cpu_pkg::DATA_WIDTH-cpu_pkg::IMM_WIDTH){1'b0}}, imm} : op_b_reg;

  assign store_data = op_b_reg;

  always_comb begin
    case (ctrl.alu_op)
      cpu_pkg::ALU_SUB: result = op_a - op_b;
      cpu_pkg::ALU_AND: result = op_a & op_b;
      cpu_pkg::ALU_OR:  result = op_a | op_b;
      cpu_pkg::ALU_SLT: begin
        result = {{(cpu_pkg::DATA_WIDTH-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      end
      default:          result = op_a + op_b;
    endcase
  end

endmodule

//--- src/cpu_pkg.sv
package cpu_pkg;

  localparam int DATA_WIDTH     = 32;
  localparam int REG_ADDR_WIDTH = 5;
  localparam int IMM_WIDTH      = 16;
  localparam int MEM_ADDR_WIDTH = 6;
  localparam int QUEUE_DEPTH    = 4;

  typedef enum logic [5:0] {
    NOP  = 6'd0,
    ADD  = 6'd1,
    SUB  = 6'd2,
    AND  = 6'd3,
    OR   = 6'd4,
    SLT  = 6'd5,
    ADDI = 6'd6,
    ORI  = 6'd7,
    LW   = 6'd8,
    SW   = 6'd9
  } opcode_e;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_SLT
  } alu_op_e;

  // register-register reading
  typedef struct packed {
    opcode_e                   opcode;
    logic [REG_ADDR_WIDTH-1:0] rs;
    logic [REG_ADDR_WIDTH-1:0] rt;
    logic [REG_ADDR_WIDTH-1:0] rd;
    logic [DATA_WIDTH-$bits(opcode_e)-3*REG_ADDR_WIDTH-1:0] tail;
  } r_fields_t;

  // immediate reading
  typedef struct packed {
    opcode_e                   opcode;
    logic [REG_ADDR_WIDTH-1:0] rs;
    logic [REG_ADDR_WIDTH-1:0] rt;
    logic [IMM_WIDTH-1:0]      imm;
  } i_fields_t;

  typedef union packed {
    r_fields_t r;
    i_fields_t i;
  } inst_u;

  typedef struct packed {
    logic    reg_write;
    logic    mem_read;
    logic    mem_write;
    logic    alu_src_imm;
    logic    dst_is_rd;
    alu_op_e alu_op;
  } ctrl_t;

  typedef enum logic [1:0] {
    FWD_RF,
    FWD_MEM,
    FWD_WB
  } fwd_sel_e;

  typedef struct packed {
    logic                      valid;
    logic [REG_ADDR_WIDTH-1:0] dest;
    logic [DATA_WIDTH-1:0]     data;
  } wb_t;

endpackage

//--- src/cpu_top.sv
`timescale 1ns/10ps

module cpu_top (
  input  logic           clk,
  input  logic           rst,
  input  logic           inst_valid,
  input  cpu_pkg::inst_u inst,
  output logic           credit_return,
  output cpu_pkg::wb_t   wb
);

  // queue and decode
  logic                           head_valid;
  cpu_pkg::inst_u                 head;
  logic                           issue;
  logic                           stall;
  cpu_pkg::ctrl_t                 id_ctrl;
  logic [cpu_pkg::DATA_WIDTH-1:0] id_rs_data;
  logic [cpu_pkg::DATA_WIDTH-1:0] id_rt_data;

  // execute
  logic                               id_ex_valid;
  cpu_pkg::inst_u                     id_ex_inst;
  cpu_pkg::ctrl_t                     id_ex_ctrl;
  logic [cpu_pkg::DATA_WIDTH-1:0]     id_ex_rs_data;
  logic [cpu_pkg::DATA_WIDTH-1:0]     id_ex_rt_data;
  logic [cpu_pkg::REG_ADDR_WIDTH-1:0] ex_dst;
  cpu_pkg::fwd_sel_e                  fwd_a;
  cpu_pkg::fwd_sel_e                  fwd_b;
  logic [cpu_pkg::DATA_WIDTH-1:0]     ex_op_a;
  logic [cpu_pkg::DATA_WIDTH-1:0]     ex_op_b;
  logic [cpu_pkg::DATA_WIDTH-1:0]     ex_result;
  logic [cpu_pkg::DATA_WIDTH-1:0]     ex_store_data;

  // memory and write-back
  logic                               ex_mem_valid;
  cpu_pkg::ctrl_t                     ex_mem_ctrl;
  logic [cpu_pkg::REG_ADDR_WIDTH-1:0] ex_mem_dst;
  logic [cpu_pkg::DATA_WIDTH-1:0]     ex_mem_result;
  logic [cpu_pkg::DATA_WIDTH-1:0]     ex_mem_store_data;
  logic [cpu_pkg::DATA_WIDTH-1:0]     mem_rdata;
  cpu_pkg::wb_t                       mem_fwd;
  cpu_pkg::wb_t                       mem_wb_next;
  cpu_pkg::wb_t                       mem_wb;

  assign wb = mem_wb;

  ////////////////////////////////////////////////////////////////////////////
  // queue and decode
  ////////////////////////////////////////////////////////////////////////////

  assign issue = head_valid && !stall;

  inst_queue i_inst_queue (
    .clk           (clk),
    .rst           (rst),
    .push          (inst_valid),
    .push_inst     (inst),
    .pop           (issue),
    .head_valid    (head_valid),
    .head          (head),
    .credit_return (credit_return)
  );

  decoder i_decoder (
    .opcode (head.r.opcode),
    .ctrl   (id_ctrl)
  );

  reg_file i_reg_file (
    .clk     (clk),
    .rst     (rst),
    .rs      (head.r.rs),
    .rt      (head.r.rt),
    .rs_data (id_rs_data),
    .rt_data (id_rt_data),
    .wr      (mem_wb)
  );

  // a stall leaves a bubble behind
  always_ff @(posedge clk) begin
    if (rst) begin
      id_ex_valid <= 1'b0;
    end else begin
      id_ex_valid <= issue;
    end
    if (issue) begin
      id_ex_inst    <= head;
      id_ex_ctrl    <= id_ctrl;
      id_ex_rs_data <= id_rs_data;
      id_ex_rt_data <= id_rt_data;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // execute
  ////////////////////////////////////////////////////////////////////////////

  assign ex_dst = id_ex_ctrl.dst_is_rd ? id_ex_inst.r.rd : id_ex_inst.i.rt;

  hazard_unit i_hazard_unit (
    .ex_rs     (id_ex_inst.r.rs),
    .ex_rt     (id_ex_inst.r.rt),
    .mem_stage (mem_fwd),
    .wb_stage  (mem_wb),
    .fwd_a     (fwd_a),
    .fwd_b     (fwd_b),
    .id_rs     (head.r.rs),
    .id_rt     (head.r.rt),
    .ex_load   (id_ex_valid && id_ex_ctrl.mem_read),
    .ex_dst    (ex_dst),
    .stall     (stall)
  );

  function automatic logic [cpu_pkg::DATA_WIDTH-1:0] fwd_value(
    input cpu_pkg::fwd_sel_e              sel,
    input logic [cpu_pkg::DATA_WIDTH-1:0] rf_value
  );
    case (sel)
      cpu_pkg::FWD_MEM: return ex_mem_result;
      cpu_pkg::FWD_WB:  return mem_wb.data;
      default:          return rf_value;
    endcase
  endfunction

  always_comb begin
    ex_op_a = fwd_value(fwd_a, id_ex_rs_data);
    ex_op_b = fwd_value(fwd_b, id_ex_rt_data);
  end

  alu i_alu (
    .op_a       (ex_op_a),
    .op_b_reg   (ex_op_b),
    .imm        (id_ex_inst.i.imm),
    .ctrl       (id_ex_ctrl),
    .result     (ex_result),
    .store_data (ex_store_data)
  );

  always_ff @(posedge clk) begin
    if (rst) begin
      ex_mem_valid <= 1'b0;
    end else begin
      ex_mem_valid <= id_ex_valid;
    end
    ex_mem_ctrl       <= id_ex_ctrl;
    ex_mem_dst        <= ex_dst;
    ex_mem_result     <= ex_result;
    ex_mem_store_data <= ex_store_data;
  end

  ////////////////////////////////////////////////////////////////////////////
  // memory and write-back
  ////////////////////////////////////////////////////////////////////////////

  // loads have nothing to forward yet
  always_comb begin
    mem_fwd.valid = ex_mem_valid && ex_mem_ctrl.reg_write && !ex_mem_ctrl.mem_read &&
                    ex_mem_dst != '0;
    mem_fwd.dest  = ex_mem_dst;
    mem_fwd.data  = ex_mem_result;
  end

  data_mem i_data_mem (
    .clk   (clk),
    .rst   (rst),
    .addr  (ex_mem_result[cpu_pkg::MEM_ADDR_WIDTH-1:0]),
    .wdata (ex_mem_store_data),
    .write (ex_mem_valid && ex_mem_ctrl.mem_write),
    .rdata (mem_rdata)
  );

  always_comb begin
    mem_wb_next.valid = ex_mem_valid && ex_mem_ctrl.reg_write && ex_mem_dst != '0;
    mem_wb_next.dest  = ex_mem_dst;
    mem_wb_next.data  = ex_mem_ctrl.mem_read ? mem_rdata : ex_mem_result;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      mem_wb.valid <= 1'b0;
    end else begin
      mem_wb <= mem_wb_next;
    end
  end

endmodule

//--- src/data_mem.sv
`timescale 1ns/10ps

module data_mem (
  input  logic                               clk,
  input  logic                               rst,
  input  logic [cpu_pkg::MEM_ADDR_WIDTH-1:0] addr,
  input  logic [cpu_pkg::DATA_WIDTH-1:0]     wdata,
  input  logic                               write,
  output logic [cpu_pkg::DATA_WIDTH-1:0]     rdata
);

  logic [cpu_pkg::DATA_WIDTH-1:0] words [2**cpu_pkg::MEM_ADDR_WIDTH];

  // combinational read for loads
  assign rdata = words[addr];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 2**cpu_pkg::MEM_ADDR_WIDTH; i++) begin
        words[i] <= '0;
      end
    end else if (write) begin
      words[addr] <= wdata;
    end
  end

endmodule

//--- src/decoder.sv
`timescale 1ns/10ps

module decoder (
  input  cpu_pkg::opcode_e opcode,
  output cpu_pkg::ctrl_t   ctrl
);

  always_comb begin
    ctrl = '0;
    case (opcode)
      cpu_pkg::ADD, cpu_pkg::SUB, cpu_pkg::AND, cpu_pkg::OR, cpu_pkg::SLT: begin
        ctrl.reg_write = 1'b1;
        ctrl.dst_is_rd = 1'b1;
      end
      cpu_pkg::ADDI, cpu_pkg::ORI, cpu_pkg::LW: begin
        ctrl.reg_write   = 1'b1;
        ctrl.alu_src_imm = 1'b1;
      end
      cpu_pkg::SW: begin
        ctrl.alu_src_imm = 1'b1;
      end
      // nop and anything unknown
      default: ctrl.reg_write = 1'b0;
    endcase

    ctrl.mem_read  = (opcode == cpu_pkg::LW);
    ctrl.mem_write = (opcode == cpu_pkg::SW);

    // loads and stores fall through to add for the address
    case (opcode)
      cpu_pkg::SUB:          ctrl.alu_op = cpu_pkg::ALU_SUB;
      cpu_pkg::AND:          ctrl.alu_op = cpu_pkg::ALU_AND;
      cpu_pkg::OR,
      cpu_pkg::ORI:          ctrl.alu_op = cpu_pkg::ALU_OR;
      cpu_pkg::SLT:          ctrl.alu_op = cpu_pkg::ALU_SLT;
      default:               ctrl.alu_op = cpu_pkg::ALU_ADD;
    endcase
  end

endmodule

//--- src/hazard_unit.sv
`timescale 1ns/10ps

module hazard_unit (
  input  logic [cpu_pkg::REG_ADDR_WIDTH-1:0] ex_rs,
  input  logic [cpu_pkg::REG_ADDR_WIDTH-1:0] ex_rt,
  input  cpu_pkg::wb_t                       mem_stage,
  input  cpu_pkg::wb_t                       wb_stage,
  output cpu_pkg::fwd_sel_e                  fwd_a,
  output cpu_pkg::fwd_sel_e                  fwd_b,
  input  logic [cpu_pkg::REG_ADDR_WIDTH-1:0] id_rs,
  input  logic [cpu_pkg::REG_ADDR_WIDTH-1:0] id_rt,
  input  logic                               ex_load,
  input  logic [cpu_pkg::REG_ADDR_WIDTH-1:0] ex_dst,
  output logic                               stall
);

  // youngest producer wins
  function automatic cpu_pkg::fwd_sel_e pick(input logic [cpu_pkg::REG_ADDR_WIDTH-1:0] src);
    if (src != '0 && mem_stage.valid && mem_stage.dest == src) begin
      return cpu_pkg::FWD_MEM;
    end else if (src != '0 && wb_stage.valid && wb_stage.dest == src) begin
      return cpu_pkg::FWD_WB;
    end
    return cpu_pkg::FWD_RF;
  endfunction

  always_comb begin
    fwd_a = pick(ex_rs);
    fwd_b = pick(ex_rt);
  end

  // load result not ready until write-back
  assign stall = ex_load && ex_dst != '0 && (ex_dst == id_rs || ex_dst == id_rt);

endmodule

//--- src/inst_queue.sv
`timescale 1ns/10ps

module inst_queue (
  input  logic           clk,
  input  logic           rst,
  input  logic           push,
  input  cpu_pkg::inst_u push_inst,
  input  logic           pop,
  output logic           head_valid,
  output cpu_pkg::inst_u head,
  output logic           credit_return
);

  cpu_pkg::inst_u entries [cpu_pkg::QUEUE_DEPTH];
  logic [$clog2(cpu_pkg::QUEUE_DEPTH)-1:0]   wr_ptr;
  logic [$clog2(cpu_pkg::QUEUE_DEPTH)-1:0]   rd_ptr;
  logic [$clog2(cpu_pkg::QUEUE_DEPTH+1)-1:0] count;
  logic full;

  assign head_valid = (count != '0);
  assign full       = (count == $bits(count)'(cpu_pkg::QUEUE_DEPTH));
  assign head       = entries[rd_ptr];

  always_ff @(posedge clk) begin
    if (push) begin
      entries[wr_ptr] <= push_inst;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr        <= '0;
      rd_ptr        <= '0;
      count         <= '0;
      credit_return <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      // one credit back per issued instruction
      credit_return <= pop;
    end
  end

  // sender must respect its credits
  assert property (@(posedge clk) disable iff (rst) !(push && full))
    else $error("instruction pushed into a full queue");

  assert property (@(posedge clk) disable iff (rst) !(pop && !head_valid))
    else $error("issue from an empty queue");

endmodule

//--- src/reg_file.sv
`timescale 1ns/10ps

module reg_file (
  input  logic                               clk,
  input  logic                               rst,
  input  logic [cpu_pkg::REG_ADDR_WIDTH-1:0] rs,
  input  logic [cpu_pkg::REG_ADDR_WIDTH-1:0] rt,
  output logic [cpu_pkg::DATA_WIDTH-1:0]     rs_data,
  output logic [cpu_pkg::DATA_WIDTH-1:0]     rt_data,
  input  cpu_pkg::wb_t                       wr
);

  logic [cpu_pkg::DATA_WIDTH-1:0] regs [2**cpu_pkg::REG_ADDR_WIDTH];

  // r0 reads zero, a same-cycle write passes straight through
  function automatic logic [cpu_pkg::DATA_WIDTH-1:0] read_port(
    input logic [cpu_pkg::REG_ADDR_WIDTH-1:0] addr
  );
    if (addr == '0) begin
      return '0;
    end else if (wr.valid && wr.dest == addr) begin
      return wr.data;
    end
    return regs[addr];
  endfunction

  always_comb begin
    rs_data = read_port(rs);
    rt_data = read_port(rt);
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 2**cpu_pkg::REG_ADDR_WIDTH; i++) begin
        regs[i] <= '0;
      end
    end else if (wr.valid && wr.dest != '0) begin
      regs[wr.dest] <= wr.data;
    end
  end

endmodule
